/* compile.f */
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_victim_sel.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the dcache testbench with Verilator, run it and judge the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module dcache_tb --Mdir "$build_dir" -f compile.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$build_dir/Vdcache_tb" > "$log_file" 2>&1; then
    cat "$log_file"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$log_file"
if grep -q "All checks passed" "$log_file"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* verif/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int NUM_TESTS   = 21;
    localparam int CYCLE_LIMIT = NUM_TESTS * 64 + 16;

    // One row per request: kind, address, data, expected read data, bus traffic
    typedef struct packed {
        logic        write;
        logic        uncached;
        logic        bp;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic        bus_chk;
        logic [1:0]  exp_bus;
    } test_t;

    test_t tests [NUM_TESTS] = '{
        '{1'b0, 1'b0, 1'b0, 32'h0000_1000, 32'h0, 32'h5a5a_0400, 1'b1, 2'd1},
        '{1'b0, 1'b0, 1'b0, 32'h0000_1000, 32'h0, 32'h5a5a_0400, 1'b1, 2'd0},
        '{1'b0, 1'b0, 1'b0, 32'h0000_1008, 32'h0, 32'h5a5a_0402, 1'b1, 2'd0},
        '{1'b1, 1'b0, 1'b0, 32'h0000_1004, 32'hcafe_0001, 32'h0, 1'b1, 2'd0},
        '{1'b0, 1'b0, 1'b0, 32'h0000_1004, 32'h0, 32'hcafe_0001, 1'b1, 2'd0},
        '{1'b1, 1'b0, 1'b0, 32'h0000_2000, 32'hbeef_0002, 32'h0, 1'b1, 2'd1},
        '{1'b0, 1'b0, 1'b0, 32'h0000_3000, 32'h0, 32'h5a5a_0c00, 1'b1, 2'd2},
        '{1'b0, 1'b0, 1'b0, 32'h0000_1004, 32'h0, 32'hcafe_0001, 1'b0, 2'd0},
        '{1'b0, 1'b0, 1'b0, 32'h0000_2000, 32'h0, 32'hbeef_0002, 1'b0, 2'd0},
        '{1'b0, 1'b1, 1'b0, 32'h8000_0010, 32'h0, 32'h7a5a_0004, 1'b1, 2'd1},
        '{1'b0, 1'b1, 1'b0, 32'h8000_0010, 32'h0, 32'h7a5a_0004, 1'b1, 2'd1},
        '{1'b1, 1'b1, 1'b0, 32'h8000_0014, 32'h1234_5678, 32'h0, 1'b1, 2'd1},
        '{1'b0, 1'b1, 1'b0, 32'h8000_0014, 32'h0, 32'h1234_5678, 1'b1, 2'd1},
        '{1'b1, 1'b0, 1'b1, 32'h0000_1040, 32'h0bad_f00d, 32'h0, 1'b1, 2'd1},
        '{1'b0, 1'b0, 1'b1, 32'h0000_1040, 32'h0, 32'h0bad_f00d, 1'b1, 2'd0},
        '{1'b0, 1'b0, 1'b1, 32'h0000_1044, 32'h0, 32'h5a5a_0411, 1'b1, 2'd0},
        '{1'b0, 1'b1, 1'b1, 32'h8000_0014, 32'h0, 32'h1234_5678, 1'b1, 2'd1},
        '{1'b0, 1'b0, 1'b1, 32'h0000_2044, 32'h0, 32'h5a5a_0811, 1'b1, 2'd1},
        '{1'b0, 1'b0, 1'b1, 32'h0000_3048, 32'h0, 32'h5a5a_0c12, 1'b0, 2'd0},
        '{1'b0, 1'b0, 1'b1, 32'h0000_1040, 32'h0, 32'h0bad_f00d, 1'b0, 2'd0},
        '{1'b0, 1'b0, 1'b1, 32'h0000_1008, 32'h0, 32'h5a5a_0402, 1'b0, 2'd0}
    };

    logic         clk_i;
    logic         rstn_i;
    logic         req_valid_i;
    logic         req_ready_o;
    logic [31:0]  req_addr_i;
    logic         req_write_i;
    logic         req_uncached_i;
    logic [31:0]  req_wdata_i;
    logic         rsp_valid_o;
    logic         rsp_ready_i;
    logic [31:0]  rsp_data_o;
    logic         mem_req_valid_o;
    logic         mem_req_ready_i;
    logic [31:0]  mem_req_addr_o;
    logic         mem_req_write_o;
    logic         mem_req_uncached_o;
    logic [127:0] mem_req_data_o;
    logic         mem_rsp_valid_i;
    logic         mem_rsp_ready_o;
    logic [127:0] mem_rsp_data_i;

    logic [31:0] mem_words [logic [31:0]];
    logic [31:0] ref_words [logic [31:0]];
    logic [31:0] bus_lfsr = 32'hbbb6_0c13;
    logic [31:0] rsp_lfsr = 32'hbbb6_0c13;
    logic        bp_on = 1'b0;
    logic [31:0] last_addr;
    logic        last_write;
    logic        last_uncached;
    int          bus_total = 0;
    int          rsp_total = 0;
    int          cycle_count = 0;
    int          errors = 0;
    int          checks = 0;

    dcache_top #(.NUM_WAYS(2)) u_dut (
        .clk_i, .rstn_i,
        .req_valid_i, .req_ready_o, .req_addr_i, .req_write_i, .req_uncached_i, .req_wdata_i,
        .rsp_valid_o, .rsp_ready_i, .rsp_data_o,
        .mem_req_valid_o, .mem_req_ready_i, .mem_req_addr_o, .mem_req_write_o,
        .mem_req_uncached_o, .mem_req_data_o,
        .mem_rsp_valid_i, .mem_rsp_ready_o, .mem_rsp_data_i
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Two LFSR bits give a delay of 0 to 3 cycles
    task automatic draw_delay(inout logic [31:0] state, output int delay);
        delay = 0;
        for (int b = 0; b < 2; b++) begin
            delay = delay * 2 + int'(state[0]);
            state = lfsr_step(state);
        end
    endtask

    // Untouched memory reads as its word address XOR a fixed pattern
    function automatic logic [31:0] mem_word(input logic [31:0] waddr);
        if (mem_words.exists(waddr)) begin
            return mem_words[waddr];
        end
        return waddr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] waddr);
        if (ref_words.exists(waddr)) begin
            return ref_words[waddr];
        end
        return waddr ^ 32'h5a5a_0000;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk_i) begin
        if (rsp_valid_o && rsp_ready_i) begin
            rsp_total++;
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // Memory bus model
    initial begin
        int           delay;
        logic [31:0]  waddr;
        logic [127:0] block;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (mem_req_valid_o) begin
                delay = 0;
                if (bp_on) begin
                    draw_delay(bus_lfsr, delay);
                end
                repeat (delay) begin
                    @(posedge clk_i);
                    #1;
                end
                bus_total++;
                last_addr     = mem_req_addr_o;
                last_write    = mem_req_write_o;
                last_uncached = mem_req_uncached_o;
                block         = '0;
                if (mem_req_uncached_o) begin
                    waddr = {2'b00, mem_req_addr_o[31:2]};
                    if (mem_req_write_o) begin
                        mem_words[waddr] = mem_req_data_o[31:0];
                    end else begin
                        block = {96'h0, mem_word(waddr)};
                    end
                end else begin
                    check_value("block alignment", {28'h0, mem_req_addr_o[3:0]}, 32'h0);
                    for (int w = 0; w < 4; w++) begin
                        waddr = {2'b00, mem_req_addr_o[31:4], w[1:0]};
                        if (mem_req_write_o) begin
                            check_value("write-back word", mem_req_data_o[w*32 +: 32],
                                        ref_word(waddr));
                            mem_words[waddr] = mem_req_data_o[w*32 +: 32];
                        end else begin
                            block[w*32 +: 32] = mem_word(waddr);
                        end
                    end
                end
                mem_req_ready_i = 1'b1;
                @(posedge clk_i);
                #1;
                mem_req_ready_i = 1'b0;
                if (!last_write) begin
                    if (bp_on) begin
                        draw_delay(bus_lfsr, delay);
                        repeat (delay) begin
                            @(posedge clk_i);
                            #1;
                        end
                    end
                    mem_rsp_data_i  = block;
                    mem_rsp_valid_i = 1'b1;
                    while (!mem_rsp_ready_o) begin
                        @(posedge clk_i);
                        #1;
                    end
                    @(posedge clk_i);
                    #1;
                    mem_rsp_valid_i = 1'b0;
                end
            end
        end
    end

    task automatic run_test(input int n);
        test_t       t;
        int          lat;
        int          delay;
        int          errs_before;
        int          bus_base;
        int          rsp_base;
        logic [31:0] exp_ref;
        logic [31:0] got;
        t           = tests[n];
        errs_before = errors;
        bus_base    = bus_total;
        rsp_base    = rsp_total;
        bp_on       = t.bp;
        rsp_ready_i = !t.bp;
        exp_ref     = ref_word(t.addr >> 2);
        req_valid_i    = 1'b1;
        req_addr_i     = t.addr;
        req_write_i    = t.write;
        req_uncached_i = t.uncached;
        req_wdata_i    = t.wdata;
        while (!req_ready_o) begin
            @(posedge clk_i);
            #1;
        end
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        lat = 0;
        if (t.write) begin
            ref_words[t.addr >> 2] = t.wdata;
        end else begin
            while (!rsp_valid_o) begin
                @(posedge clk_i);
                #1;
                lat++;
            end
            got = rsp_data_o;
            if (t.bp) begin
                draw_delay(rsp_lfsr, delay);
                repeat (delay) begin
                    @(posedge clk_i);
                    #1;
                    lat++;
                end
                check_value("held rsp_valid_o", 32'(rsp_valid_o), 32'h1);
                check_value("held rsp_data_o", rsp_data_o, got);
                rsp_ready_i = 1'b1;
            end
            @(posedge clk_i);
            #1;
            lat++;
            rsp_ready_i = !t.bp;
            check_value("read data", got, t.exp_data);
            check_value("reference data", got, exp_ref);
            if (!t.uncached && !t.bp && t.bus_chk && t.exp_bus == 2'd0) begin
                check_value("hit latency", lat, 32'd2);
            end
        end
        while (!req_ready_o) begin
            @(posedge clk_i);
            #1;
        end
        check_value("response count", rsp_total - rsp_base, t.write ? 0 : 1);
        check_value("rsp_valid_o when idle", 32'(rsp_valid_o), 32'h0);
        if (t.bus_chk) begin
            check_value("bus request count", bus_total - bus_base, 32'(t.exp_bus));
        end
        if (bus_total != bus_base) begin
            check_value("bus uncached flag", 32'(last_uncached), 32'(t.uncached));
            check_value("bus write flag", 32'(last_write), 32'(t.uncached & t.write));
            if (t.uncached) begin
                check_value("bus address", last_addr, t.addr);
            end
        end
        $display("test %0d %s%s addr %h: %s", n, t.uncached ? "uncached " : "",
                 t.write ? "write" : "read", t.addr, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rstn_i         = 1'b0;
        req_valid_i    = 1'b0;
        req_addr_i     = '0;
        req_write_i    = 1'b0;
        req_uncached_i = 1'b0;
        req_wdata_i    = '0;
        rsp_ready_i    = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        check_value("req_ready_o after reset", 32'(req_ready_o), 32'h1);
        check_value("rsp_valid_o after reset", 32'(rsp_valid_o), 32'h0);
        check_value("mem_req_valid_o after reset", 32'(mem_req_valid_o), 32'h0);
        check_value("mem_rsp_ready_o after reset", 32'(mem_rsp_ready_o), 32'h0);
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_test(n);
        end
        $display("%0d tests run, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int NUM_WAYS = 2
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  logic [ADDR_W-1:0]  req_addr_i,
    input  logic               req_write_i,
    input  logic               req_uncached_i,
    input  logic [WORD_W-1:0]  req_wdata_i,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output logic [WORD_W-1:0]  rsp_data_o,
    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    output logic [ADDR_W-1:0]  mem_req_addr_o,
    output logic               mem_req_write_o,
    output logic               mem_req_uncached_o,
    output logic [BLOCK_W-1:0] mem_req_data_o,
    input  logic               mem_rsp_valid_i,
    output logic               mem_rsp_ready_o,
    input  logic [BLOCK_W-1:0] mem_rsp_data_i
);

    localparam int WAY_W = way_w(NUM_WAYS);

    logic [INDEX_W-1:0]               index;
    logic [TAG_W-1:0]                 tag;
    logic                             upd;
    logic [WAY_W-1:0]                 upd_way;
    logic [TAG_W-1:0]                 upd_tag;
    logic                             upd_valid;
    logic                             upd_dirty;
    logic                             hit;
    logic [WAY_W-1:0]                 hit_way;
    logic [NUM_WAYS-1:0]              set_valid;
    logic [NUM_WAYS-1:0]              set_dirty;
    logic [NUM_WAYS-1:0][TAG_W-1:0]   set_tags;
    logic [WSEL_W-1:0]                word_sel;
    logic                             wr_word;
    logic                             fill;
    logic [WAY_W-1:0]                 way;
    logic [WORD_W-1:0]                wdata;
    logic [BLOCK_W-1:0]               fill_data;
    logic [NUM_WAYS-1:0][BLOCK_W-1:0] set_blocks;
    logic [WAY_W-1:0]                 victim_way;

    dcache_tag_store #(.NUM_WAYS(NUM_WAYS)) u_tag_store (
        .clk_i, .rstn_i,
        .index_i(index), .tag_i(tag),
        .upd_i(upd), .upd_way_i(upd_way), .upd_tag_i(upd_tag),
        .upd_valid_i(upd_valid), .upd_dirty_i(upd_dirty),
        .hit_o(hit), .hit_way_o(hit_way),
        .set_valid_o(set_valid), .set_dirty_o(set_dirty), .set_tags_o(set_tags)
    );

    dcache_data_store #(.NUM_WAYS(NUM_WAYS)) u_data_store (
        .clk_i,
        .index_i(index), .word_sel_i(word_sel),
        .wr_word_i(wr_word), .wdata_i(wdata),
        .fill_i(fill), .fill_data_i(fill_data),
        .way_i(way), .set_blocks_o(set_blocks)
    );

    dcache_victim_sel #(.NUM_WAYS(NUM_WAYS)) u_victim_sel (
        .clk_i, .rstn_i,
        .set_valid_i(set_valid), .victim_way_o(victim_way)
    );

    dcache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
        .clk_i, .rstn_i,
        .req_valid_i, .req_ready_o, .req_addr_i, .req_write_i, .req_uncached_i, .req_wdata_i,
        .rsp_valid_o, .rsp_ready_i, .rsp_data_o,
        .mem_req_valid_o, .mem_req_ready_i, .mem_req_addr_o, .mem_req_write_o,
        .mem_req_uncached_o, .mem_req_data_o,
        .mem_rsp_valid_i, .mem_rsp_ready_o, .mem_rsp_data_i,
        .index_o(index), .tag_o(tag),
        .upd_o(upd), .upd_way_o(upd_way), .upd_tag_o(upd_tag),
        .upd_valid_o(upd_valid), .upd_dirty_o(upd_dirty),
        .hit_i(hit), .hit_way_i(hit_way), .set_dirty_i(set_dirty), .set_tags_i(set_tags),
        .word_sel_o(word_sel), .wr_word_o(wr_word), .fill_o(fill), .way_o(way),
        .wdata_o(wdata), .fill_data_o(fill_data),
        .set_blocks_i(set_blocks), .victim_way_i(victim_way)
    );

endmodule

`default_nettype wire

/* logic/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
    parameter int NUM_WAYS = 2,
    localparam int WAY_W = way_w(NUM_WAYS)
) (
    input  logic                             clk_i,
    input  logic                             rstn_i,
    // Requesting port
    input  logic                             req_valid_i,
    output logic                             req_ready_o,
    input  logic [ADDR_W-1:0]                req_addr_i,
    input  logic                             req_write_i,
    input  logic                             req_uncached_i,
    input  logic [WORD_W-1:0]                req_wdata_i,
    output logic                             rsp_valid_o,
    input  logic                             rsp_ready_i,
    output logic [WORD_W-1:0]                rsp_data_o,
    // Memory bus
    output logic                             mem_req_valid_o,
    input  logic                             mem_req_ready_i,
    output logic [ADDR_W-1:0]                mem_req_addr_o,
    output logic                             mem_req_write_o,
    output logic                             mem_req_uncached_o,
    output logic [BLOCK_W-1:0]               mem_req_data_o,
    input  logic                             mem_rsp_valid_i,
    output logic                             mem_rsp_ready_o,
    input  logic [BLOCK_W-1:0]               mem_rsp_data_i,
    // Tag store
    output logic [INDEX_W-1:0]               index_o,
    output logic [TAG_W-1:0]                 tag_o,
    output logic                             upd_o,
    output logic [WAY_W-1:0]                 upd_way_o,
    output logic [TAG_W-1:0]                 upd_tag_o,
    output logic                             upd_valid_o,
    output logic                             upd_dirty_o,
    input  logic                             hit_i,
    input  logic [WAY_W-1:0]                 hit_way_i,
    input  logic [NUM_WAYS-1:0]              set_dirty_i,
    input  logic [NUM_WAYS-1:0][TAG_W-1:0]   set_tags_i,
    // Data store and victim choice
    output logic [WSEL_W-1:0]                word_sel_o,
    output logic                             wr_word_o,
    output logic                             fill_o,
    output logic [WAY_W-1:0]                 way_o,
    output logic [WORD_W-1:0]                wdata_o,
    output logic [BLOCK_W-1:0]               fill_data_o,
    input  logic [NUM_WAYS-1:0][BLOCK_W-1:0] set_blocks_i,
    input  logic [WAY_W-1:0]                 victim_way_i
);

    ctrl_state_e       state_q;
    cache_addr_u       addr_q;
    logic              write_q;
    logic [WORD_W-1:0] wdata_q;
    logic [WAY_W-1:0]  victim_q;
    logic [BLOCK_W-1:0] hit_block;
    logic [ADDR_W-1:0] fill_addr;
    logic [ADDR_W-1:0] evict_addr;

    assign hit_block  = set_blocks_i[hit_way_i];
    assign fill_addr  = {addr_q.fields.tag, addr_q.fields.index, {OFFSET_W{1'b0}}};
    // Victim line lives in the same set, so only its tag differs
    assign evict_addr = {set_tags_i[victim_way_i], addr_q.fields.index, {OFFSET_W{1'b0}}};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q         <= IDLE;
            rsp_valid_o     <= 1'b0;
            mem_req_valid_o <= 1'b0;
            mem_rsp_ready_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_valid_i) begin
                        addr_q.raw <= req_addr_i;
                        write_q    <= req_write_i;
                        wdata_q    <= req_wdata_i;
                        if (req_uncached_i) begin
                            mem_req_valid_o    <= 1'b1;
                            mem_req_addr_o     <= req_addr_i;
                            mem_req_write_o    <= req_write_i;
                            mem_req_uncached_o <= 1'b1;
                            mem_req_data_o     <= {{(BLOCK_W - WORD_W){1'b0}}, req_wdata_i};
                            state_q            <= UNC_REQ;
                        end else begin
                            state_q <= LOOKUP;
                        end
                    end
                end
                LOOKUP: begin
                    if (hit_i && write_q) begin
                        state_q <= IDLE;
                    end else if (hit_i) begin
                        rsp_valid_o <= 1'b1;
                        rsp_data_o  <= hit_block[addr_q.fields.word_sel*WORD_W +: WORD_W];
                        state_q     <= RESPOND;
                    end else begin
                        victim_q           <= victim_way_i;
                        mem_req_valid_o    <= 1'b1;
                        mem_req_uncached_o <= 1'b0;
                        if (set_dirty_i[victim_way_i]) begin
                            mem_req_addr_o  <= evict_addr;
                            mem_req_data_o  <= set_blocks_i[victim_way_i];
                            mem_req_write_o <= 1'b1;
                            state_q         <= EVICT_REQ;
                        end else begin
                            mem_req_addr_o  <= fill_addr;
                            mem_req_write_o <= 1'b0;
                            state_q         <= FILL_REQ;
                        end
                    end
                end
                EVICT_REQ: begin
                    // Write-back taken, follow straight on with the refill read
                    if (mem_req_ready_i) begin
                        mem_req_addr_o  <= fill_addr;
                        mem_req_write_o <= 1'b0;
                        state_q         <= FILL_REQ;
                    end
                end
                FILL_REQ: begin
                    if (mem_req_ready_i) begin
                        mem_req_valid_o <= 1'b0;
                        mem_rsp_ready_o <= 1'b1;
                        state_q         <= FILL_WAIT;
                    end
                end
                FILL_WAIT: begin
                    if (mem_rsp_valid_i) begin
                        mem_rsp_ready_o <= 1'b0;
                        state_q         <= LOOKUP;
                    end
                end
                UNC_REQ: begin
                    if (mem_req_ready_i) begin
                        mem_req_valid_o <= 1'b0;
                        if (write_q) begin
                            state_q <= IDLE;
                        end else begin
                            mem_rsp_ready_o <= 1'b1;
                            state_q         <= UNC_WAIT;
                        end
                    end
                end
                UNC_WAIT: begin
                    if (mem_rsp_valid_i) begin
                        mem_rsp_ready_o <= 1'b0;
                        rsp_valid_o     <= 1'b1;
                        rsp_data_o      <= mem_rsp_data_i[WORD_W-1:0];
                        state_q         <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (rsp_ready_i) begin
                        rsp_valid_o <= 1'b0;
                        state_q     <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign req_ready_o = (state_q == IDLE);

    assign index_o    = addr_q.fields.index;
    assign tag_o      = addr_q.fields.tag;
    assign word_sel_o = addr_q.fields.word_sel;
    assign wdata_o    = wdata_q;
    assign fill_data_o = mem_rsp_data_i;

    // Array writes happen on the write hit and on the refill beat
    assign wr_word_o = (state_q == LOOKUP) && hit_i && write_q;
    assign fill_o    = (state_q == FILL_WAIT) && mem_rsp_valid_i;
    assign way_o     = (state_q == FILL_WAIT) ? victim_q : hit_way_i;

    assign upd_o       = wr_word_o || fill_o;
    assign upd_way_o   = way_o;
    assign upd_tag_o   = addr_q.fields.tag;
    assign upd_valid_o = 1'b1;
    assign upd_dirty_o = wr_word_o;

    a_mem_req_hold: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o
            && $stable({mem_req_addr_o, mem_req_write_o, mem_req_uncached_o, mem_req_data_o})
    );

    a_rsp_hold: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o)
    );

endmodule

`default_nettype wire

/* logic/dcache_victim_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_victim_sel import dcache_pkg::*; #(
    parameter int NUM_WAYS = 2,
    localparam int WAY_W = way_w(NUM_WAYS)
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic [NUM_WAYS-1:0] set_valid_i,
    output logic [WAY_W-1:0]    victim_way_o
);

    logic [WAY_W-1:0] rr_q;

    // Free running round-robin pointer
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_q <= '0;
        end else if (rr_q == WAY_W'(NUM_WAYS - 1)) begin
            rr_q <= '0;
        end else begin
            rr_q <= rr_q + 1'b1;
        end
    end

    // Lowest invalid way wins, scan from the top so it ends up last
    always_comb begin
        victim_way_o = rr_q;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid_i[w]) begin
                victim_way_o = WAY_W'(w);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store import dcache_pkg::*; #(
    parameter int NUM_WAYS = 2,
    localparam int WAY_W = way_w(NUM_WAYS)
) (
    input  logic                             clk_i,
    input  logic [INDEX_W-1:0]               index_i,
    input  logic [WSEL_W-1:0]                word_sel_i,
    input  logic                             wr_word_i,
    input  logic [WORD_W-1:0]                wdata_i,
    input  logic                             fill_i,
    input  logic [BLOCK_W-1:0]               fill_data_i,
    input  logic [WAY_W-1:0]                 way_i,
    output logic [NUM_WAYS-1:0][BLOCK_W-1:0] set_blocks_o
);

    logic [NUM_WAYS-1:0][BLOCK_W-1:0] blocks_q [NUM_SETS];

    // Whole line on refill, single word on a write hit
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            blocks_q[index_i][way_i] <= fill_data_i;
        end else if (wr_word_i) begin
            blocks_q[index_i][way_i][word_sel_i*WORD_W +: WORD_W] <= wdata_i;
        end
    end

    assign set_blocks_o = blocks_q[index_i];

    // Controller issues these strobes from different states
    a_word_fill_exclusive: assert property (
        @(posedge clk_i) !(wr_word_i && fill_i)
    );

endmodule

`default_nettype wire

/* logic/dcache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store import dcache_pkg::*; #(
    parameter int NUM_WAYS = 2,
    localparam int WAY_W = way_w(NUM_WAYS)
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic [INDEX_W-1:0]             index_i,
    input  logic [TAG_W-1:0]               tag_i,
    input  logic                           upd_i,
    input  logic [WAY_W-1:0]               upd_way_i,
    input  logic [TAG_W-1:0]               upd_tag_i,
    input  logic                           upd_valid_i,
    input  logic                           upd_dirty_i,
    output logic                           hit_o,
    output logic [WAY_W-1:0]               hit_way_o,
    output logic [NUM_WAYS-1:0]            set_valid_o,
    output logic [NUM_WAYS-1:0]            set_dirty_o,
    output logic [NUM_WAYS-1:0][TAG_W-1:0] set_tags_o
);

    logic [NUM_WAYS-1:0][TAG_W-1:0] tags_q [NUM_SETS];
    logic [NUM_WAYS-1:0]            valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0]            dirty_q [NUM_SETS];
    logic [NUM_WAYS-1:0]            match;

    // Line state bits, cleared on reset
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (upd_i) begin
            valid_q[index_i][upd_way_i] <= upd_valid_i;
            dirty_q[index_i][upd_way_i] <= upd_dirty_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd_i) begin
            tags_q[index_i][upd_way_i] <= upd_tag_i;
        end
    end

    assign set_valid_o = valid_q[index_i];
    assign set_dirty_o = dirty_q[index_i];
    assign set_tags_o  = tags_q[index_i];

    // Compare every way of the addressed set
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = valid_q[index_i][w] && (tags_q[index_i][w] == tag_i);
            if (match[w]) begin
                hit_way_o = WAY_W'(w);
            end
        end
    end

    assign hit_o = |match;

    // A refill never installs a tag that is already present in the set
    a_single_hit: assert property (
        @(posedge clk_i) disable iff (!rstn_i) $onehot0(match)
    );

endmodule

`default_nettype wire

/* logic/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // Address and data geometry
    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int BLOCK_W  = 128;
    localparam int NUM_SETS = 16;
    localparam int INDEX_W  = 4;
    localparam int WSEL_W   = 2;
    localparam int BSEL_W   = 2;
    localparam int OFFSET_W = WSEL_W + BSEL_W;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // Width of a way number, at least one bit even for a direct mapped cache
    function automatic int way_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // Raw view goes to the bus for uncached accesses, field view feeds lookups
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic [WSEL_W-1:0]  word_sel;
            logic [BSEL_W-1:0]  byte_sel;
        } fields;
    } cache_addr_u;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        EVICT_REQ,
        FILL_REQ,
        FILL_WAIT,
        UNC_REQ,
        UNC_WAIT
    } ctrl_state_e;

endpackage

`default_nettype wire
